// File: verilog/mecobo_consts.svh
// widths, pin count, register map and waveform codes
`ifndef MECOBO_CONSTS_SVH
`define MECOBO_CONSTS_SVH

// bus word and word address widths
`define WORD_W 16
`define ADDR_W 8

// pin controller bank
`define NUM_PINS   8
`define PIN_STRIDE 4

// register offsets inside one pin's block of words
`define REG_WAVE   2'd0
`define REG_PERIOD 2'd1
`define REG_DUTY   2'd2
`define REG_TICK   2'd3

// waveform codes held in the wave register
`define WAVE_OFF    2'd0
`define WAVE_SQUARE 2'd1
`define WAVE_PWM    2'd2
`define WAVE_HIGH   2'd3

// serial DAC window, placed above the pin range
`define DAC_BASE   8'h40
`define DAC_DATA   8'd0
`define DAC_STATUS 8'd1

`endif

// File: verilog/mecobo_pkg.sv
// shared word, address and waveform types, DAC state enum
`include "mecobo_consts.svh"

package mecobo_pkg;

  // one bus or register word
  typedef logic [`WORD_W-1:0] word_t;

  // word address on the register bus
  typedef logic [`ADDR_W-1:0] reg_addr_t;

  // waveform select code of a pin
  typedef logic [1:0] wave_sel_t;

  // serial DAC sequencer states
  typedef enum logic [1:0] {
    DAC_IDLE,
    DAC_SHIFT,
    DAC_LOAD
  } dac_state_t;

endpackage

// File: verilog/wb_reg_port.sv
// Wishbone classic slave: address decode, write strobes, read mux, DAC stall
`timescale 1ns/1ps
`include "mecobo_consts.svh"

module wb_reg_port (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  mecobo_pkg::reg_addr_t wb_adr,
  input  mecobo_pkg::word_t     wb_dat_w,
  output mecobo_pkg::word_t     wb_dat_r,
  output logic                  wb_ack,
  output mecobo_pkg::reg_addr_t reg_addr,
  output mecobo_pkg::word_t     wr_data,
  output logic                  pin_wr,
  output logic                  dac_wr,
  input  mecobo_pkg::word_t     pin_rdata,
  input  mecobo_pkg::word_t     dac_rdata,
  input  logic                  dac_busy
);
  import mecobo_pkg::*;

  localparam int PIN_SPAN = `NUM_PINS * `PIN_STRIDE;
  localparam reg_addr_t DAC_DATA_ADDR = reg_addr_t'(`DAC_BASE + `DAC_DATA);
  localparam reg_addr_t DAC_STATUS_ADDR = reg_addr_t'(`DAC_BASE + `DAC_STATUS);

  logic  pin_hit;
  logic  dac_hit;
  logic  stall;
  logic  req;
  word_t read_word;

  // master holds address and data until ack, so both pass straight through
  assign reg_addr = wb_adr;
  assign wr_data  = wb_dat_w;

  assign pin_hit = (int'(wb_adr) < PIN_SPAN);
  assign dac_hit = (wb_adr == DAC_DATA_ADDR) || (wb_adr == DAC_STATUS_ADDR);

  // new word for the converter has to wait until the current one is out
  assign stall = wb_we && (wb_adr == DAC_DATA_ADDR) && dac_busy;

  // a request not yet answered
  assign req = wb_cyc && wb_stb && !wb_ack;

  // unmapped addresses read as zero
  always_comb begin
    if (pin_hit) begin
      read_word = pin_rdata;
    end else if (dac_hit) begin
      read_word = dac_rdata;
    end else begin
      read_word = '0;
    end
  end

  // single-cycle ack, one cycle after the strobe is seen
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req && !stall;
    end
  end

  // reply word captured together with the ack
  always_ff @(posedge sys_clk) begin
    if (req && !stall) begin
      wb_dat_r <= read_word;
    end
  end

  // write strobes line up with the ack cycle
  assign pin_wr = wb_ack && wb_we && pin_hit;
  assign dac_wr = wb_ack && wb_we && dac_hit;

endmodule

// File: verilog/pin_controller.sv
// one output pin: wave, period and duty registers, tick counter, waveform compare
`timescale 1ns/1ps
`include "mecobo_consts.svh"

module pin_controller (
  input  logic              sys_clk,
  input  logic              reset,
  input  logic              wr,
  input  logic [1:0]        reg_offset,
  input  mecobo_pkg::word_t wr_data,
  output mecobo_pkg::word_t rdata,
  output logic              pin
);
  import mecobo_pkg::*;

  wave_sel_t wave;
  word_t     period;
  word_t     duty;
  word_t     tick;
  logic      restart;
  logic      level;

  // new waveform or period starts the cycle over
  assign restart = wr && ((reg_offset == `REG_WAVE) || (reg_offset == `REG_PERIOD));

  // configuration registers, tick is read only
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      wave   <= `WAVE_OFF;
      period <= '0;
      duty   <= '0;
    end else if (wr) begin
      case (reg_offset)
        `REG_WAVE:   wave   <= wr_data[1:0];
        `REG_PERIOD: period <= wr_data;
        `REG_DUTY:   duty   <= wr_data;
        default:     ;
      endcase
    end
  end

  // free-running tick, wraps at period-1
  always_ff @(posedge sys_clk) begin
    if (reset || restart) begin
      tick <= '0;
    end else if (period == '0) begin
      // zero period parks the counter
      tick <= '0;
    end else if (tick >= period - 1'b1) begin
      tick <= '0;
    end else begin
      tick <= tick + 1'b1;
    end
  end

  // level for the current tick
  always_comb begin
    case (wave)
      `WAVE_SQUARE: level = (tick < (period >> 1));
      `WAVE_PWM:    level = (tick < duty);
      `WAVE_HIGH:   level = 1'b1;
      default:      level = 1'b0;
    endcase
  end

  // registered so the pin trails the tick by one cycle
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      pin <= 1'b0;
    end else begin
      pin <= level;
    end
  end

  // readback
  always_comb begin
    case (reg_offset)
      `REG_WAVE:   rdata = word_t'(wave);
      `REG_PERIOD: rdata = period;
      `REG_DUTY:   rdata = duty;
      default:     rdata = tick;
    endcase
  end

endmodule

// File: verilog/pin_bank.sv
// bank of pin controllers with write steering and read select
`timescale 1ns/1ps
`include "mecobo_consts.svh"

module pin_bank (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  mecobo_pkg::reg_addr_t reg_addr,
  input  mecobo_pkg::word_t     wr_data,
  input  logic                  pin_wr,
  output mecobo_pkg::word_t     pin_rdata,
  output logic [`NUM_PINS-1:0]  pins
);
  import mecobo_pkg::*;

  localparam int IDX_W = $clog2(`NUM_PINS);
  localparam int OFS_W = $clog2(`PIN_STRIDE);

  logic [IDX_W-1:0] pin_idx;
  logic [OFS_W-1:0] reg_offset;
  word_t            rdata_arr [`NUM_PINS];

  // low bits pick the register, the bits above pick the pin
  assign reg_offset = reg_addr[OFS_W-1:0];
  assign pin_idx    = reg_addr[OFS_W +: IDX_W];

  genvar p;
  generate
    for (p = 0; p < `NUM_PINS; p++) begin : gen_pin
      logic pin_sel_wr;

      // only the addressed controller sees the write
      assign pin_sel_wr = pin_wr && (pin_idx == IDX_W'(p));

      pin_controller pin_controller_inst (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .wr         (pin_sel_wr),
        .reg_offset (reg_offset),
        .wr_data    (wr_data),
        .rdata      (rdata_arr[p]),
        .pin        (pins[p])
      );
    end
  endgenerate

  // addressed pin's word, port zeroes it outside the pin range
  assign pin_rdata = rdata_arr[pin_idx];

endmodule

// File: verilog/dac_control.sv
// serial DAC: word register, divided serial clock, sync and load sequencing, status
`timescale 1ns/1ps
`include "mecobo_consts.svh"

module dac_control (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  mecobo_pkg::reg_addr_t reg_addr,
  input  mecobo_pkg::word_t     wr_data,
  input  logic                  dac_wr,
  output mecobo_pkg::word_t     dac_rdata,
  output logic                  dac_busy,
  output logic                  dac_sclk,
  output logic                  dac_nsync,
  output logic                  dac_nldac,
  output logic                  dac_din
);
  import mecobo_pkg::*;

  localparam reg_addr_t DATA_ADDR   = reg_addr_t'(`DAC_BASE + `DAC_DATA);
  localparam reg_addr_t STATUS_ADDR = reg_addr_t'(`DAC_BASE + `DAC_STATUS);

  // two sys_clk cycles per serial bit
  localparam int CNT_W = $clog2(2 * `WORD_W);
  localparam logic [CNT_W-1:0] LAST_HALF = CNT_W'(2 * `WORD_W - 1);

  dac_state_t       state;
  word_t            dac_data;
  word_t            shreg;
  logic [CNT_W-1:0] half_cnt;
  logic             start;

  // status writes are accepted but do nothing
  assign start = dac_wr && (reg_addr == DATA_ADDR) && (state == DAC_IDLE);

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state     <= DAC_IDLE;
      half_cnt  <= '0;
      dac_sclk  <= 1'b0;
      dac_nsync <= 1'b1;
      dac_nldac <= 1'b1;
      dac_data  <= '0;
      shreg     <= '0;
    end else begin
      case (state)
        DAC_IDLE: begin
          if (start) begin
            // MSB is on din one cycle before the first rising sclk
            state     <= DAC_SHIFT;
            dac_data  <= wr_data;
            shreg     <= wr_data;
            half_cnt  <= '0;
            dac_nsync <= 1'b0;
          end
        end
        DAC_SHIFT: begin
          dac_sclk <= ~dac_sclk;
          half_cnt <= half_cnt + 1'b1;
          // next bit goes out on the falling edge
          if (dac_sclk) begin
            shreg <= {shreg[`WORD_W-2:0], 1'b0};
          end
          if (half_cnt == LAST_HALF) begin
            // 16th bit taken, close the frame and pulse load
            state     <= DAC_LOAD;
            dac_nsync <= 1'b1;
            dac_nldac <= 1'b0;
          end
        end
        DAC_LOAD: begin
          dac_nldac <= 1'b1;
          state     <= DAC_IDLE;
        end
        default: begin
          state <= DAC_IDLE;
        end
      endcase
    end
  end

  assign dac_din  = shreg[`WORD_W-1];
  assign dac_busy = (state != DAC_IDLE);

  // readback of last word and busy flag
  always_comb begin
    if (reg_addr == DATA_ADDR) begin
      dac_rdata = dac_data;
    end else if (reg_addr == STATUS_ADDR) begin
      dac_rdata = word_t'(dac_busy);
    end else begin
      dac_rdata = '0;
    end
  end

endmodule

// File: verilog/mecobo_top.sv
// top level: Wishbone port, pin bank and serial DAC controller
`timescale 1ns/1ps
`include "mecobo_consts.svh"

module mecobo_top (
  input  logic                  sys_clk,
  input  logic                  reset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  mecobo_pkg::reg_addr_t wb_adr,
  input  mecobo_pkg::word_t     wb_dat_w,
  output mecobo_pkg::word_t     wb_dat_r,
  output logic                  wb_ack,
  output logic [`NUM_PINS-1:0]  pins,
  output logic                  dac_sclk,
  output logic                  dac_nsync,
  output logic                  dac_nldac,
  output logic                  dac_din
);
  import mecobo_pkg::*;

  // shared register bus
  reg_addr_t reg_addr;
  word_t     wr_data;
  logic      pin_wr;
  logic      dac_wr;
  word_t     pin_rdata;
  word_t     dac_rdata;
  logic      dac_busy;

  wb_reg_port wb_reg_port_inst (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .reg_addr  (reg_addr),
    .wr_data   (wr_data),
    .pin_wr    (pin_wr),
    .dac_wr    (dac_wr),
    .pin_rdata (pin_rdata),
    .dac_rdata (dac_rdata),
    .dac_busy  (dac_busy)
  );

  pin_bank pin_bank_inst (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .reg_addr  (reg_addr),
    .wr_data   (wr_data),
    .pin_wr    (pin_wr),
    .pin_rdata (pin_rdata),
    .pins      (pins)
  );

  dac_control dac_control_inst (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .reg_addr  (reg_addr),
    .wr_data   (wr_data),
    .dac_wr    (dac_wr),
    .dac_rdata (dac_rdata),
    .dac_busy  (dac_busy),
    .dac_sclk  (dac_sclk),
    .dac_nsync (dac_nsync),
    .dac_nldac (dac_nldac),
    .dac_din   (dac_din)
  );

endmodule

// File: sim/tb_clock.sv
// testbench clock source and power-on reset
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 4
) (
  output logic sys_clk,
  output logic reset
);

  initial begin
    sys_clk = 1'b0;
    forever #HALF_PERIOD sys_clk = ~sys_clk;
  end

  // released just after an edge, like the other inputs
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    #1;
    reset = 1'b0;
  end

endmodule

// File: sim/mecobo_tb.sv
// testbench for mecobo_top: bus tasks, waveform and DAC checks, watchdog, report
`timescale 1ns/1ps
`include "mecobo_consts.svh"

module mecobo_tb;
  import mecobo_pkg::*;

  localparam int CLK_PERIOD      = 10;
  localparam int EXPECTED_CYCLES = 20000;
  localparam int WATCHDOG_NS     = EXPECTED_CYCLES * CLK_PERIOD * 2;
  localparam int ACK_LIMIT       = 100;
  localparam reg_addr_t DAC_DATA_ADDR   = reg_addr_t'(`DAC_BASE + `DAC_DATA);
  localparam reg_addr_t DAC_STATUS_ADDR = reg_addr_t'(`DAC_BASE + `DAC_STATUS);

  logic                 sys_clk;
  logic                 reset;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  reg_addr_t            wb_adr;
  word_t                wb_dat_w;
  word_t                wb_dat_r;
  logic                 wb_ack;
  logic [`NUM_PINS-1:0] pins;
  logic                 dac_sclk;
  logic                 dac_nsync;
  logic                 dac_nldac;
  logic                 dac_din;

  int        mismatches = 0;
  int        failures = 0;
  int        frames = 0;
  int        nldac_pulses = 0;
  int        bit_cnt = 0;
  int        stall_cycles = 0;
  logic      prev_sclk;
  logic      prev_nsync;
  word_t     shift_word;
  word_t     expect_q [$];
  reg_addr_t unmapped [4] = '{8'h20, 8'h3F, 8'h42, 8'hFF};

  tb_clock tb_clock_inst (.*);

  mecobo_top mecobo_top_inst (.*);

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("%s at %0t", msg, $time);
  endtask

  // one classic cycle, held through the ack cycle and released after it
  task automatic wb_access(input logic we, input reg_addr_t adr, input word_t wdat,
                           output word_t rdat);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(posedge sys_clk);
      #1;
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    assert (wb_ack) else report_failure($sformatf("no ack for address %h", adr));
    rdat = wb_dat_r;
    @(posedge sys_clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input reg_addr_t adr, input word_t data);
    word_t ignored;
    wb_access(1'b1, adr, data, ignored);
  endtask

  task automatic wb_read(input reg_addr_t adr, output word_t data);
    wb_access(1'b0, adr, '0, data);
  endtask

  function automatic reg_addr_t pin_addr(input int idx, input int ofs);
    return reg_addr_t'(idx * `PIN_STRIDE + ofs);
  endfunction

  task automatic set_pin(input int idx, input wave_sel_t wave, input word_t period,
                         input word_t duty);
    wb_write(pin_addr(idx, `REG_PERIOD), period);
    wb_write(pin_addr(idx, `REG_DUTY), duty);
    wb_write(pin_addr(idx, `REG_WAVE), word_t'(wave));
  endtask

  // high cycles of one pin over a window, sampled mid-cycle
  task automatic count_high(input int idx, input int len, output int highs);
    highs = 0;
    repeat (2) @(negedge sys_clk);
    repeat (len) begin
      @(negedge sys_clk);
      if (pins[idx]) begin
        highs++;
      end
    end
    @(posedge sys_clk);
    #1;
  endtask

  task automatic wait_dac_idle();
    word_t status;
    int    polls;
    polls  = 0;
    status = 16'h1;
    while (status != '0 && polls < ACK_LIMIT) begin
      wb_read(DAC_STATUS_ADDR, status);
      polls++;
    end
    assert (status == '0) else report_failure("DAC status never returned to idle");
  endtask

  // DAC frame capture and bus stall watch, sampled mid-cycle
  always @(negedge sys_clk) begin
    if (!reset) begin
      if (!dac_nsync && dac_sclk && !prev_sclk) begin
        shift_word = {shift_word[`WORD_W-2:0], dac_din};
        bit_cnt++;
      end
      if (dac_nsync && !prev_nsync) begin
        frames++;
        assert (bit_cnt == `WORD_W)
          else report_failure($sformatf("DAC frame carried %0d bits", bit_cnt));
        assert (expect_q.size() > 0) else report_failure("DAC frame without a written word");
        if (expect_q.size() > 0) begin
          check_word("dac_din word", shift_word, expect_q.pop_front());
        end
        bit_cnt = 0;
      end
      if (!dac_nldac) begin
        nldac_pulses++;
        assert (dac_nsync && !prev_nsync)
          else report_failure("dac_nldac low outside the cycle that ends a frame");
      end
      if (wb_ack && wb_we && wb_adr == DAC_DATA_ADDR) begin
        assert (!dac_busy_seen()) else report_failure("DAC write acknowledged while busy");
      end
      if (wb_stb && wb_we && wb_adr == DAC_DATA_ADDR && !wb_ack && dac_busy_seen()) begin
        stall_cycles++;
      end
    end
    prev_sclk  = dac_sclk;
    prev_nsync = dac_nsync;
  end

  // busy as seen from the pins: a frame or its load pulse in progress
  function automatic logic dac_busy_seen();
    return !dac_nsync || !dac_nldac;
  endfunction

  initial begin
    wave_sel_t   wave;
    word_t       period;
    word_t       duty;
    word_t       rd;
    word_t       data;
    int          highs;
    int unsigned seed;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    seed     = 32'h539c1528;
    data     = word_t'($urandom(seed));
    @(negedge reset);
    @(negedge sys_clk);
    check_word("wb_ack", word_t'(wb_ack), '0);
    check_word("pins", word_t'(pins), '0);
    check_word("dac_sclk", word_t'(dac_sclk), '0);
    check_word("dac_nsync", word_t'(dac_nsync), 16'h1);
    check_word("dac_nldac", word_t'(dac_nldac), 16'h1);
    @(posedge sys_clk);
    #1;

    for (int p = 0; p < `NUM_PINS; p++) begin
      wave = wave_sel_t'($urandom % 4);
      // even pins get short periods so the tick read lands after a wrap
      if (p % 2 == 0) begin
        period = word_t'($urandom % 6 + 1);
      end else begin
        period = word_t'($urandom % 500 + 1);
      end
      duty   = word_t'($urandom);
      set_pin(p, wave, period, duty);
      wb_read(pin_addr(p, `REG_WAVE), rd);
      check_word("wave", rd, word_t'(wave));
      wb_read(pin_addr(p, `REG_PERIOD), rd);
      check_word("period", rd, period);
      wb_read(pin_addr(p, `REG_DUTY), rd);
      check_word("duty", rd, duty);
      wb_read(pin_addr(p, `REG_TICK), rd);
      assert (rd < period)
        else report_failure($sformatf("tick %h not below period %h", rd, period));
    end
    foreach (unmapped[i]) begin
      wb_write(unmapped[i], word_t'($urandom));
      wb_read(unmapped[i], rd);
      check_word("unmapped read", rd, '0);
    end

    // square wave, even and odd periods in turn, window at a random offset
    for (int i = 0; i < 6; i++) begin
      period = word_t'(2 * ($urandom % 20 + 2) + i % 2);
      set_pin(0, `WAVE_SQUARE, period, '0);
      repeat ($urandom % 7) @(negedge sys_clk);
      count_high(0, period, highs);
      check_word("square high count", word_t'(highs), period / 2);
    end

    // duty both below and above the period
    for (int i = 0; i < 6; i++) begin
      period = word_t'($urandom % 40 + 4);
      duty   = word_t'($urandom % (period + 8));
      set_pin(1, `WAVE_PWM, period, duty);
      repeat ($urandom % 7) @(negedge sys_clk);
      count_high(1, period, highs);
      check_word("pwm high count", word_t'(highs), (duty < period) ? duty : period);
    end
    set_pin(2, `WAVE_HIGH, 16'd5, '0);
    set_pin(3, `WAVE_OFF, 16'd5, 16'd5);
    count_high(2, 50, highs);
    check_word("high level count", word_t'(highs), 16'd50);
    count_high(3, 50, highs);
    check_word("off level count", word_t'(highs), '0);

    data = word_t'($urandom);
    expect_q.push_back(data);
    wb_write(DAC_DATA_ADDR, data);
    wb_read(DAC_STATUS_ADDR, rd);
    check_word("dac status", rd, 16'h1);
    wait_dac_idle();
    wb_read(DAC_DATA_ADDR, rd);
    check_word("dac data", rd, data);

    // second word lands while the first is still shifting
    for (int i = 0; i < 2; i++) begin
      data = word_t'($urandom);
      expect_q.push_back(data);
      wb_write(DAC_DATA_ADDR, data);
    end
    wait_dac_idle();
    wb_read(DAC_DATA_ADDR, rd);
    check_word("dac data", rd, data);
    assert (stall_cycles >= 2 * `WORD_W)
      else report_failure($sformatf("second DAC write held off for only %0d cycles",
                                    stall_cycles));
    assert (expect_q.size() == 0) else report_failure("DAC words missing on dac_din");
    assert (frames == 3 && nldac_pulses == frames)
      else report_failure($sformatf("%0d frames, %0d load pulses", frames, nldac_pulses));

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // twice the expected run length
  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before the tests finished");
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: flist.f
+incdir+verilog
verilog/mecobo_pkg.sv
verilog/wb_reg_port.sv
verilog/pin_controller.sv
verilog/pin_bank.sv
verilog/dac_control.sv
verilog/mecobo_top.sv
sim/tb_clock.sv
sim/mecobo_tb.sv
